//--- files.f
source/classifierPkg.sv
source/hiddenNeuron.sv
source/hiddenBank.sv
source/outputLayer.sv
source/glyphClassifier.sv
bench/glyphClassifierBench.sv

//--- Makefile
TOP = glyphClassifierBench

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f source/*.sv bench/*.sv
	verilator --binary --timing --timescale 1ns/100ps \
		--top-module $(TOP) -f files.f -o V$(TOP)

lint:
	verilator --lint-only -Wall --top-module glyphClassifier \
		source/classifierPkg.sv \
		source/hiddenNeuron.sv \
		source/hiddenBank.sv \
		source/outputLayer.sv \
		source/glyphClassifier.sv

clean:
	rm -rf obj_dir

//--- bench/glyphClassifierBench.sv
`default_nettype none

module glyphClassifierBench;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int randomRunCount = 300;
	localparam int gapRunCount = 200;
	localparam int extremeCount = 4;
	localparam int handMadeCount = classifierPkg::classCount;
	localparam int vectorCount = randomRunCount + gapRunCount + extremeCount + handMadeCount;

	// Two clock periods per vector, plus room for reset and draining
	localparam int watchdogNs = vectorCount * 4 * 2 + 200;

	logic clk;
	logic reset;
	logic inValid;
	classifierPkg::PixelVector pixels;
	logic outValid;
	classifierPkg::ClassIndex classIndex;
	classifierPkg::Accumulator winningScore;

	int seed = 32'h3e39_dd87;
	int cycleCount = 0;

	classifierPkg::ClassIndex expectedClass [$];
	classifierPkg::Accumulator expectedScore [$];
	int dueCycle [$];

	glyphClassifier DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.pixels(pixels),
		.outValid(outValid),
		.classIndex(classIndex),
		.winningScore(winningScore)
	);

	always #2 clk = ~clk;

	// ########################################################################
	// Reference model and checks

	function automatic void classify(input classifierPkg::PixelVector glyph,
		output classifierPkg::ClassIndex bestClass, output classifierPkg::Accumulator bestScore);
		int hiddenSum;
		int activations [classifierPkg::hiddenCount];
		int score;
		int topScore;
		int scale;
		scale = 1 << classifierPkg::fracBits;
		for (int n = 0; n < classifierPkg::hiddenCount; n++)
		begin
			hiddenSum = int'(classifierPkg::hiddenBias[n]) * scale;
			for (int i = 0; i < classifierPkg::pixelCount; i++)
			begin
				hiddenSum = hiddenSum + int'(glyph[i]) * int'(classifierPkg::hiddenWeights[n][i]);
			end
			hiddenSum = hiddenSum >>> classifierPkg::fracBits;
			if (hiddenSum < 0)
			begin
				activations[n] = 0;
			end
			else if (hiddenSum > 127)
			begin
				activations[n] = 127;
			end
			else
			begin
				activations[n] = hiddenSum;
			end
		end
		topScore = 0;
		bestClass = '0;
		for (int c = 0; c < classifierPkg::classCount; c++)
		begin
			score = int'(classifierPkg::outputBias[c]) * scale;
			for (int n = 0; n < classifierPkg::hiddenCount; n++)
			begin
				score = score + activations[n] * int'(classifierPkg::outputWeights[c][n]);
			end
			// Lowest index keeps a tie
			if (c == 0 || score > topScore)
			begin
				topScore = score;
				bestClass = classifierPkg::ClassIndex'(c);
			end
		end
		bestScore = classifierPkg::Accumulator'(topScore);
	endfunction

	task automatic stopOnError(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkClass(input classifierPkg::ClassIndex got,
		input classifierPkg::ClassIndex expected, input string what);
		if (got !== expected)
		begin
			stopOnError($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, got, expected));
		end
	endtask

	task automatic checkScore(input classifierPkg::Accumulator got,
		input classifierPkg::Accumulator expected, input string what);
		if (got !== expected)
		begin
			stopOnError($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, got, expected));
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin : compareResults
		classifierPkg::ClassIndex refClass;
		classifierPkg::Accumulator refScore;
		cycleCount = cycleCount + 1;
		if (inValid)
		begin
			classify(pixels, refClass, refScore);
			expectedClass.push_back(refClass);
			expectedScore.push_back(refScore);
			dueCycle.push_back(cycleCount + classifierPkg::pipelineDepth);
		end
		if (outValid)
		begin
			if (dueCycle.size() == 0)
			begin
				stopOnError($sformatf("Error at %0t ns: outValid is high with no glyph in flight",
					$time));
			end
			else if (dueCycle[0] != cycleCount)
			begin
				stopOnError($sformatf("Error at %0t ns: result came in cycle %0d, due in cycle %0d",
					$time, cycleCount, dueCycle[0]));
			end
			else
			begin
				refClass = expectedClass.pop_front();
				refScore = expectedScore.pop_front();
				void'(dueCycle.pop_front());
				checkClass(classIndex, refClass, "classIndex");
				checkScore(winningScore, refScore, "winningScore");
			end
		end
		else if (dueCycle.size() != 0 && dueCycle[0] == cycleCount)
		begin
			stopOnError($sformatf("Error at %0t ns: outValid stayed low when a result was due",
				$time));
		end
	end

	// ########################################################################
	// Stimulus

	function automatic classifierPkg::PixelVector randomGlyph();
		classifierPkg::PixelVector glyph;
		int randomValue;
		for (int i = 0; i < classifierPkg::pixelCount; i++)
		begin
			randomValue = $random(seed);
			glyph[i] = randomValue[7:0];
		end
		return glyph;
	endfunction

	function automatic classifierPkg::PixelVector patternGlyph(input classifierPkg::Pixel evenValue,
		input classifierPkg::Pixel oddValue);
		classifierPkg::PixelVector glyph;
		for (int i = 0; i < classifierPkg::pixelCount; i++)
		begin
			glyph[i] = (i % 2 == 0) ? evenValue : oddValue;
		end
		return glyph;
	endfunction

	// Sign pattern of the hidden row that the class weighs most
	function automatic classifierPkg::PixelVector signGlyph(input int classNumber);
		classifierPkg::PixelVector glyph;
		classifierPkg::Weight w;
		int strongest;
		strongest = 0;
		for (int n = 1; n < classifierPkg::hiddenCount; n++)
		begin
			if (classifierPkg::outputWeights[classNumber][n]
				> classifierPkg::outputWeights[classNumber][strongest])
			begin
				strongest = n;
			end
		end
		for (int i = 0; i < classifierPkg::pixelCount; i++)
		begin
			w = classifierPkg::hiddenWeights[strongest][i];
			glyph[i] = w[7] ? 8'sh80 : 8'sh7f;
		end
		return glyph;
	endfunction

	task automatic sendGlyph(input classifierPkg::PixelVector glyph);
		inValid = 1'b1;
		pixels = glyph;
		@(posedge clk);
		#0.5;
		inValid = 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			#0.5;
		end
	endtask

	initial
	begin : stimulus
		classifierPkg::ClassIndex refClass;
		classifierPkg::Accumulator refScore;
		classifierPkg::PixelVector glyph;
		int gap;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		pixels = '0;
		repeat (3)
		begin
			@(posedge clk);
		end
		#0.5;
		reset = 1'b0;

		// Quiet pipeline after reset
		idle(10);

		// Several glyphs in flight at once
		for (int k = 0; k < randomRunCount; k++)
		begin
			sendGlyph(randomGlyph());
		end
		idle(classifierPkg::pipelineDepth + 2);

		for (int k = 0; k < gapRunCount; k++)
		begin
			sendGlyph(randomGlyph());
			gap = $unsigned($random(seed)) % 3;
			idle(gap);
		end
		idle(classifierPkg::pipelineDepth + 2);

		// Saturating glyphs hit both ends of the clamp
		sendGlyph(patternGlyph(8'sh7f, 8'sh7f));
		sendGlyph(patternGlyph(8'sh80, 8'sh80));
		sendGlyph(patternGlyph(8'sh7f, 8'sh80));
		sendGlyph(patternGlyph(8'sh80, 8'sh7f));
		idle(classifierPkg::pipelineDepth + 2);

		for (int c = 0; c < handMadeCount; c++)
		begin
			glyph = signGlyph(c);
			classify(glyph, refClass, refScore);
			checkClass(refClass, classifierPkg::ClassIndex'(c), "reference class of hand-made glyph");
			sendGlyph(glyph);
			idle(2);
		end
		idle(classifierPkg::pipelineDepth + 2);

		if (dueCycle.size() != 0)
		begin
			stopOnError($sformatf("Error at end of run: %0d results never appeared",
				dueCycle.size()));
		end
		else
		begin
			$display("Regression passed");
			$finish;
		end
	end

	initial
	begin : watchdog
		#(watchdogNs);
		stopOnError($sformatf("Watchdog expired after %0d ns, the simulation hung", watchdogNs));
	end

endmodule

`default_nettype wire

//--- source/glyphClassifier.sv
`default_nettype none

module glyphClassifier
(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire classifierPkg::PixelVector pixels,
	output logic outValid,
	output classifierPkg::ClassIndex classIndex,
	output classifierPkg::Accumulator winningScore
);

	logic lowValid;
	classifierPkg::ActivationVector lowActivations;
	classifierPkg::ActivationVector highActivations;

	// ########################################################################
	// Hidden layer

	// Neurons 0 to 3
	hiddenBank #(
		.firstNeuron(0)
	) lowBank (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.pixels(pixels),
		.bankValid(lowValid),
		.activations(lowActivations)
	);

	// Neurons 4 to 7
	// Runs in lockstep with lowBank, so its valid output is left open
	hiddenBank #(
		.firstNeuron(classifierPkg::bankSize)
	) highBank (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.pixels(pixels),
		.bankValid(),
		.activations(highActivations)
	);

	// ########################################################################
	// Output layer

	outputLayer scoring (
		.clk(clk),
		.reset(reset),
		.inValid(lowValid),
		.activationsLow(lowActivations),
		.activationsHigh(highActivations),
		.outValid(outValid),
		.classIndex(classIndex),
		.winningScore(winningScore)
	);

endmodule

`default_nettype wire

//--- source/outputLayer.sv
`default_nettype none

module outputLayer
(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire classifierPkg::ActivationVector activationsLow,
	input wire classifierPkg::ActivationVector activationsHigh,
	output logic outValid,
	output classifierPkg::ClassIndex classIndex,
	output classifierPkg::Accumulator winningScore
);

	classifierPkg::Activation [classifierPkg::hiddenCount-1:0] allActivations;
	classifierPkg::Accumulator scoreNext [classifierPkg::classCount];
	classifierPkg::Accumulator scores [classifierPkg::classCount];
	classifierPkg::ClassIndex bestIndex;
	classifierPkg::Accumulator bestScore;
	logic scoreValid;

	// Low bank holds neurons 0 to 3
	assign allActivations = {activationsHigh, activationsLow};

	// ########################################################################
	// Class scores in the first stage

	// Activations are zero-extended so they stay non-negative operands
	always_comb
	begin
		for (int c = 0; c < classifierPkg::classCount; c++)
		begin
			scoreNext[c] = classifierPkg::Accumulator'(classifierPkg::outputBias[c])
				<<< classifierPkg::fracBits;
			for (int n = 0; n < classifierPkg::hiddenCount; n++)
			begin
				scoreNext[c] = scoreNext[c]
					+ classifierPkg::Accumulator'(allActivations[n])
					* classifierPkg::Accumulator'(classifierPkg::outputWeights[c][n]);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scoreValid <= 1'b0;
			scores <= '{default: '0};
		end
		else
		begin
			scoreValid <= inValid;
			if (inValid)
			begin
				scores <= scoreNext;
			end
		end
	end

	// ########################################################################
	// Maximum selection in the second stage

	// Strict compare keeps the lower index on a tie
	always_comb
	begin
		bestIndex = '0;
		bestScore = scores[0];
		for (int c = 1; c < classifierPkg::classCount; c++)
		begin
			if (scores[c] > bestScore)
			begin
				bestIndex = classifierPkg::ClassIndex'(c);
				bestScore = scores[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
			classIndex <= '0;
			winningScore <= '0;
		end
		else
		begin
			outValid <= scoreValid;
			if (scoreValid)
			begin
				classIndex <= bestIndex;
				winningScore <= bestScore;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/hiddenBank.sv
`default_nettype none

module hiddenBank #(
	parameter int firstNeuron = 0
)
(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire classifierPkg::PixelVector pixels,
	output logic bankValid,
	output classifierPkg::ActivationVector activations
);

	classifierPkg::PixelVector pixelRegister;
	logic pixelValid;

	// ########################################################################
	// Input capture and valid pipeline

	// Pixels are only taken on a strobe and held between glyphs
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pixelRegister <= '0;
			pixelValid <= 1'b0;
		end
		else
		begin
			pixelValid <= inValid;
			if (inValid)
			begin
				pixelRegister <= pixels;
			end
		end
	end

	// Matches the activation register inside each neuron
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bankValid <= 1'b0;
		end
		else
		begin
			bankValid <= pixelValid;
		end
	end

	// ########################################################################
	// Neurons

	for (genvar n = 0; n < classifierPkg::bankSize; n++)
	begin : neuron
		hiddenNeuron #(
			.neuronIndex(firstNeuron + n)
		) neuronInst (
			.clk(clk),
			.reset(reset),
			.pixels(pixelRegister),
			.activation(activations[n])
		);
	end

endmodule

`default_nettype wire

//--- source/hiddenNeuron.sv
`default_nettype none

module hiddenNeuron #(
	parameter int neuronIndex = 0
)
(
	input wire clk,
	input wire reset,
	input wire classifierPkg::PixelVector pixels,
	output classifierPkg::Activation activation
);

	classifierPkg::Accumulator weightedSum;
	classifierPkg::Accumulator scaledSum;
	classifierPkg::Activation clampedValue;

	// Bias is moved up to the scale of the pixel-weight products
	always_comb
	begin
		weightedSum = classifierPkg::Accumulator'(classifierPkg::hiddenBias[neuronIndex])
			<<< classifierPkg::fracBits;
		for (int i = 0; i < classifierPkg::pixelCount; i++)
		begin
			weightedSum = weightedSum
				+ classifierPkg::Accumulator'($signed(pixels[i]))
				* classifierPkg::Accumulator'(classifierPkg::hiddenWeights[neuronIndex][i]);
		end
	end

	// Back to pixel scale
	assign scaledSum = weightedSum >>> classifierPkg::fracBits;

	// Rectifier with saturation at the top of the activation range
	always_comb
	begin
		if (scaledSum < 0)
		begin
			clampedValue = '0;
		end
		else if (scaledSum > 20'sd127)
		begin
			clampedValue = '1;
		end
		else
		begin
			clampedValue = scaledSum[6:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else
		begin
			activation <= clampedValue;
		end
	end

endmodule

`default_nettype wire

//--- source/classifierPkg.sv
`default_nettype none

package classifierPkg;

	// ########################################################################
	// Sizes

	localparam int pixelCount = 15;
	localparam int hiddenCount = 8;
	localparam int bankSize = 4;
	localparam int classCount = 3;
	localparam int fracBits = 6;

	// Two cycles in a hidden bank, two in the output layer
	localparam int pipelineDepth = 4;

	// ########################################################################
	// Types

	typedef logic signed [7:0] Pixel;
	typedef Pixel [pixelCount-1:0] PixelVector;

	// Q1.6 coefficient
	typedef logic signed [7:0] Weight;

	// Holds fifteen full-range products plus the shifted bias
	typedef logic signed [19:0] Accumulator;

	typedef logic [6:0] Activation;
	typedef Activation [bankSize-1:0] ActivationVector;
	typedef logic [1:0] ClassIndex;

	// ########################################################################
	// Hidden layer coefficients

	// Rows 0 to 2 are the class feature detectors, one third of the glyph each
	localparam Weight hiddenWeights [hiddenCount][pixelCount] = '{
		'{8'sd36, 8'sd40, 8'sd34, 8'sd38, 8'sd32, -8'sd18, -8'sd22, -8'sd20,
			-8'sd16, -8'sd24, -8'sd20, -8'sd18, -8'sd22, -8'sd16, -8'sd20},
		'{-8'sd20, -8'sd16, -8'sd22, -8'sd18, -8'sd24, 8'sd38, 8'sd34, 8'sd40,
			8'sd32, 8'sd36, -8'sd18, -8'sd20, -8'sd16, -8'sd22, -8'sd18},
		'{-8'sd22, -8'sd18, -8'sd20, -8'sd24, -8'sd16, -8'sd20, -8'sd18, -8'sd16,
			-8'sd22, -8'sd20, 8'sd34, 8'sd38, 8'sd36, 8'sd40, 8'sd32},
		'{8'sd66, -8'sd44, -8'sd18, 8'sd53, 8'sd90, -8'sd97, 8'sd6, 8'sd51,
			8'sd19, -8'sd8, -8'sd38, 8'sd41, -8'sd13, 8'sd73, 8'sd66},
		'{-8'sd12, 8'sd25, 8'sd47, -8'sd60, 8'sd8, 8'sd14, -8'sd33, 8'sd29,
			-8'sd71, 8'sd55, 8'sd3, -8'sd19, 8'sd62, -8'sd40, 8'sd11},
		'{8'sd17, -8'sd9, 8'sd0, 8'sd31, -8'sd45, 8'sd58, 8'sd22, -8'sd64,
			8'sd13, -8'sd27, 8'sd49, 8'sd7, -8'sd36, 8'sd20, -8'sd5},
		'{-8'sd50, 8'sd43, 8'sd12, -8'sd7, 8'sd26, -8'sd15, 8'sd68, 8'sd4,
			-8'sd29, 8'sd37, -8'sd58, 8'sd24, 8'sd9, -8'sd11, 8'sd35},
		'{8'sd28, 8'sd6, -8'sd41, 8'sd19, -8'sd23, 8'sd45, -8'sd3, -8'sd52,
			8'sd61, 8'sd10, 8'sd16, -8'sd67, 8'sd30, 8'sd2, -8'sd14}
	};

	localparam Weight hiddenBias [hiddenCount] = '{
		-8'sd7, 8'sd4, -8'sd10, 8'sd12, -8'sd5, 8'sd8, -8'sd3, 8'sd6
	};

	// ########################################################################
	// Output layer coefficients

	// Each class leans on its own detector and against the other two
	localparam Weight outputWeights [classCount][hiddenCount] = '{
		'{8'sd60, -8'sd30, -8'sd30, 8'sd5, -8'sd4, 8'sd3, -8'sd6, 8'sd2},
		'{-8'sd30, 8'sd60, -8'sd30, -8'sd3, 8'sd6, -8'sd5, 8'sd4, -8'sd2},
		'{-8'sd30, -8'sd30, 8'sd60, 8'sd2, -8'sd5, 8'sd6, -8'sd3, 8'sd4}
	};

	localparam Weight outputBias [classCount] = '{
		8'sd10, -8'sd6, 8'sd4
	};

endpackage

`default_nettype wire
